/* logic/eth_fcs_pkg.sv */
//**************************************************************************
// Types and constants shared by the 64-bit Ethernet FCS inserter.
// Modules import it in their bodies and use scoped names in port lists.
//**************************************************************************

`default_nettype none

package eth_fcs_pkg;

    localparam int LANES = 8;

    typedef logic [8*LANES-1:0] data_t;
    typedef logic [LANES-1:0] keep_t;
    typedef logic [31:0] crc_t;

    // valid bytes in one beat, 0 to 8
    typedef logic [3:0] lane_count_t;

    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        logic  user;
    } beat_t;

    // entry n is the crc after bytes 0 to n
    typedef crc_t [LANES-1:0] crc_bank_t;

    localparam crc_t CRC_INIT = 32'hffff_ffff;

    // reflected form of 0x04c11db7
    localparam crc_t CRC_POLY = 32'hedb8_8320;

    typedef enum logic [1:0] {
        idle,
        payload,
        fcs
    } framer_state_e;

endpackage

`default_nettype wire

/* logic/eth_crc_64.sv */
//**************************************************************************
// Combinational CRC-32 step over the eight byte lanes of one beat.
// Returns the running CRC after every byte, so any byte count can be used.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module eth_crc_64 (
    input  wire eth_fcs_pkg::crc_t      crc_state,
    input  wire eth_fcs_pkg::data_t     data,
    output eth_fcs_pkg::crc_bank_t      crc_bank
);

    import eth_fcs_pkg::*;

    crc_t crc;
    logic [7:0] data_byte;

    // lane 0 first, each byte shifted in lsb first
    always_comb begin
        crc = crc_state;
        data_byte = '0;
        for (int i = 0; i < LANES; i++) begin
            data_byte = data[8*i +: 8];
            crc = crc ^ {24'd0, data_byte};
            for (int b = 0; b < 8; b++) begin
                if (crc[0]) begin
                    crc = (crc >> 1) ^ CRC_POLY;
                end else begin
                    crc = crc >> 1;
                end
            end
            crc_bank[i] = crc;
        end
    end

endmodule

`default_nettype wire

/* logic/fcs_splice.sv */
//**************************************************************************
// Places the inverted CRC after the last valid byte of a final beat.
// Bytes that do not fit spill into the low lanes of an overflow beat.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module fcs_splice (
    input  wire eth_fcs_pkg::data_t     data,
    input  wire eth_fcs_pkg::keep_t     keep,
    input  wire eth_fcs_pkg::crc_bank_t crc_bank,
    output eth_fcs_pkg::data_t          final_data,
    output eth_fcs_pkg::keep_t          final_keep,
    output eth_fcs_pkg::data_t          extra_data,
    output eth_fcs_pkg::keep_t          extra_keep
);

    import eth_fcs_pkg::*;

    lane_count_t         n;
    crc_t                fcs_value;
    // twelve lanes, final beat below and overflow above
    logic [8*LANES+31:0] span_data;
    logic [LANES+3:0]    span_keep;

    always_comb begin
        n = '0;
        for (int i = 0; i < LANES; i++) begin
            n = n + lane_count_t'(keep[i]);
        end
    end

    // n of 8 wraps to entry 7
    assign fcs_value = ~crc_bank[n[2:0] - 3'd1];

    always_comb begin
        if (n == '0) begin
            span_data = {32'd0, data};
            span_keep = {4'd0, keep};
        end else begin
            span_data = {32'd0, data} | ({64'd0, fcs_value} << (8 * n));
            span_keep = {4'd0, keep} | (12'h00f << n);
        end
    end

    assign final_data = span_data[8*LANES-1:0];
    assign final_keep = span_keep[LANES-1:0];
    assign extra_data = {32'd0, span_data[8*LANES+31:8*LANES]};
    assign extra_keep = {4'd0, span_keep[LANES+3:LANES]};

    always_comb begin
        if (keep != '0) begin
            assert ((keep & (keep + 8'd1)) == 8'd0)
                else $error("keep %b is not contiguous from lane 0", keep);
        end
    end

endmodule

`default_nettype wire

/* logic/fcs_framer.sv */
//**************************************************************************
// Frame state machine of the FCS inserter. Masks input bytes, keeps the
// running CRC, emits the spliced final beat and the overflow FCS beat.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module fcs_framer (
    input  wire                         clk,
    input  wire                         rst,
    input  wire eth_fcs_pkg::beat_t     in_beat,
    input  wire                         in_valid,
    output logic                        in_ready,
    input  wire eth_fcs_pkg::crc_bank_t crc_bank,
    input  wire eth_fcs_pkg::data_t     final_data,
    input  wire eth_fcs_pkg::data_t     extra_data,
    input  wire eth_fcs_pkg::keep_t     final_keep,
    input  wire eth_fcs_pkg::keep_t     extra_keep,
    output eth_fcs_pkg::crc_t           crc_state,
    output eth_fcs_pkg::data_t          masked_data,
    output eth_fcs_pkg::beat_t          int_beat,
    output logic                        int_valid,
    input  wire                         ready,
    input  wire                         ready_early,
    output logic                        busy
);

    import eth_fcs_pkg::*;

    framer_state_e state;
    framer_state_e state_next;
    logic          in_ready_next;
    logic          accept;
    logic          reset_crc;
    logic          update_crc;
    logic          store_extra;

    // fcs bytes held for the overflow beat
    data_t         extra_data_reg;
    keep_t         extra_keep_reg;

    assign accept = in_valid && in_ready;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            masked_data[8*i +: 8] = in_beat.keep[i] ? in_beat.data[8*i +: 8] : 8'd0;
        end
    end

    always_comb begin
        state_next    = state;
        in_ready_next = 1'b0;
        reset_crc     = 1'b0;
        update_crc    = 1'b0;
        store_extra   = 1'b0;
        int_beat      = '{data: masked_data, keep: in_beat.keep, last: 1'b0, user: 1'b0};
        int_valid     = 1'b0;

        case (state)
            idle, payload: begin
                in_ready_next = ready_early;
                int_valid     = accept;
                if (accept) begin
                    if (!in_beat.last) begin
                        update_crc = 1'b1;
                        state_next = payload;
                    end else if (in_beat.user) begin
                        // aborted frame goes out as is
                        int_beat.last = 1'b1;
                        int_beat.user = 1'b1;
                        reset_crc     = 1'b1;
                        state_next    = idle;
                    end else begin
                        int_beat.data = final_data;
                        int_beat.keep = final_keep;
                        reset_crc     = 1'b1;
                        if (extra_keep == '0) begin
                            int_beat.last = 1'b1;
                            state_next    = idle;
                        end else begin
                            // fcs spills, hold input for one beat
                            store_extra   = 1'b1;
                            in_ready_next = 1'b0;
                            state_next    = fcs;
                        end
                    end
                end
            end
            fcs: begin
                int_beat  = '{data: extra_data_reg, keep: extra_keep_reg,
                              last: 1'b1, user: 1'b0};
                int_valid = ready;
                if (ready) begin
                    in_ready_next = ready_early;
                    state_next    = idle;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            in_ready  <= 1'b0;
            busy      <= 1'b0;
            crc_state <= CRC_INIT;
        end else begin
            state    <= state_next;
            in_ready <= in_ready_next;
            busy     <= (state_next != idle);
            if (reset_crc) begin
                crc_state <= CRC_INIT;
            end else if (update_crc) begin
                crc_state <= crc_bank[LANES-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_extra) begin
            extra_data_reg <= extra_data;
            extra_keep_reg <= extra_keep;
        end
    end

    // in_ready must track the skid register's ready
    int_valid_needs_ready: assert property (
        @(posedge clk) disable iff (rst) int_valid |-> ready
    ) else $error("beat offered while output register not ready");

endmodule

`default_nettype wire

/* logic/axis_skid_reg.sv */
//**************************************************************************
// Output register with a temporary slot for the FCS inserter.
// Keeps full throughput while its own ready stays a register.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module axis_skid_reg (
    input  wire                     clk,
    input  wire                     rst,
    input  wire eth_fcs_pkg::beat_t int_beat,
    input  wire                     int_valid,
    output logic                    ready,
    output logic                    ready_early,
    output eth_fcs_pkg::beat_t      out_beat,
    output logic                    out_valid,
    input  wire                     out_ready
);

    import eth_fcs_pkg::*;

    beat_t temp_beat;
    logic  temp_valid;
    logic  out_valid_next;
    logic  temp_valid_next;
    logic  load_out_from_int;
    logic  load_out_from_temp;
    logic  load_temp;

    // stay ready unless the temp slot might have to take a beat
    assign ready_early = out_ready || (!temp_valid && (!out_valid || !int_valid));

    always_comb begin
        out_valid_next     = out_valid;
        temp_valid_next    = temp_valid;
        load_out_from_int  = 1'b0;
        load_out_from_temp = 1'b0;
        load_temp          = 1'b0;

        if (ready) begin
            if (out_ready || !out_valid) begin
                out_valid_next    = int_valid;
                load_out_from_int = 1'b1;
            end else begin
                // output stalled, park the beat in flight
                temp_valid_next = int_valid;
                load_temp       = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next     = temp_valid;
            temp_valid_next    = 1'b0;
            load_out_from_temp = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
            ready      <= 1'b0;
        end else begin
            out_valid  <= out_valid_next;
            temp_valid <= temp_valid_next;
            ready      <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_from_int) begin
            out_beat <= int_beat;
        end else if (load_out_from_temp) begin
            out_beat <= temp_beat;
        end
        if (load_temp) begin
            temp_beat <= int_beat;
        end
    end

    out_stable_when_stalled: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat)
    ) else $error("output beat changed while stalled");

endmodule

`default_nettype wire

/* logic/eth_fcs_insert_64.sv */
//**************************************************************************
// 64-bit AXI4-Stream Ethernet FCS inserter, top level.
// Appends the CRC-32 to each frame; aborted frames pass without FCS.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module eth_fcs_insert_64 (
    input  wire                     clk,
    input  wire                     rst,
    input  wire eth_fcs_pkg::beat_t in_beat,
    input  wire                     in_valid,
    output logic                    in_ready,
    output eth_fcs_pkg::beat_t      out_beat,
    output logic                    out_valid,
    input  wire                     out_ready,
    output logic                    busy
);

    import eth_fcs_pkg::*;

    crc_t      crc_state;
    data_t     masked_data;
    crc_bank_t crc_bank;
    data_t     final_data;
    data_t     extra_data;
    keep_t     final_keep;
    keep_t     extra_keep;
    beat_t     int_beat;
    logic      int_valid;
    logic      skid_ready;
    logic      skid_ready_early;

    fcs_framer fcs_framer_inst (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (in_beat),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .crc_bank    (crc_bank),
        .final_data  (final_data),
        .extra_data  (extra_data),
        .final_keep  (final_keep),
        .extra_keep  (extra_keep),
        .crc_state   (crc_state),
        .masked_data (masked_data),
        .int_beat    (int_beat),
        .int_valid   (int_valid),
        .ready       (skid_ready),
        .ready_early (skid_ready_early),
        .busy        (busy)
    );

    eth_crc_64 eth_crc_64_inst (
        .crc_state (crc_state),
        .data      (masked_data),
        .crc_bank  (crc_bank)
    );

    fcs_splice fcs_splice_inst (
        .data       (masked_data),
        .keep       (in_beat.keep),
        .crc_bank   (crc_bank),
        .final_data (final_data),
        .final_keep (final_keep),
        .extra_data (extra_data),
        .extra_keep (extra_keep)
    );

    axis_skid_reg axis_skid_reg_inst (
        .clk         (clk),
        .rst         (rst),
        .int_beat    (int_beat),
        .int_valid   (int_valid),
        .ready       (skid_ready),
        .ready_early (skid_ready_early),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

`default_nettype wire

/* sim/tb_eth_fcs_insert.sv */
//**************************************************************************
// Self-checking testbench for the 64-bit Ethernet FCS inserter.
// Sends random frames, some aborted, and checks every output frame
// against a bytewise CRC-32 model, with and without back-pressure.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_eth_fcs_insert;

    import eth_fcs_pkg::*;

    typedef logic [7:0] byte_q_t[$];

    localparam int FRAMES     = 150;
    localparam int WAIT_LIMIT = 2000;

    logic    clk;
    logic    rst;
    beat_t   in_beat;
    logic    in_valid;
    logic    in_ready;
    beat_t   out_beat;
    logic    out_valid;
    logic    out_ready;
    logic    busy;

    integer  seed;
    logic    stall_enable;
    logic    gap_enable;

    // expected output, frame boundaries kept in exp_len
    byte_q_t exp_bytes;
    int      exp_len[$];
    logic    exp_abort[$];

    byte_q_t got_bytes;
    int      got_beats;
    int      frames_sent;
    int      frames_seen;
    int      data_errors;
    int      protocol_errors;
    int      timeouts;
    logic    busy_seen;
    logic    was_stalled;
    beat_t   stalled_beat;

    eth_fcs_insert_64 eth_fcs_insert_64_inst (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .busy      (busy)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ethernet crc-32, reflected, each byte lsb first
    function automatic byte_q_t expected_bytes(input byte_q_t payload, input logic aborted);
        byte_q_t     result;
        logic [31:0] crc;
        logic        feedback;
        result = payload;
        if (!aborted) begin
            crc = 32'hffff_ffff;
            foreach (payload[k]) begin
                for (int b = 0; b < 8; b++) begin
                    feedback = crc[0] ^ payload[k][b];
                    crc = {1'b0, crc[31:1]};
                    if (feedback) begin
                        crc = crc ^ 32'hedb8_8320;
                    end
                end
            end
            // inverted, low byte first on the wire
            for (int j = 0; j < 4; j++) begin
                result.push_back(~crc[8*j +: 8]);
            end
        end
        return result;
    endfunction

    function automatic keep_t low_lanes(input int count);
        keep_t mask;
        for (int i = 0; i < LANES; i++) begin
            mask[i] = (i < count);
        end
        return mask;
    endfunction

    task automatic send_beat(input beat_t b);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        in_beat  = b;
        in_valid = 1'b1;
        while (!accepted && waited < WAIT_LIMIT) begin
            @(posedge clk);
            accepted = in_ready;
            waited++;
        end
        if (!accepted) begin
            timeouts++;
            $display("input beat was not accepted within %0d cycles", WAIT_LIMIT);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic send_frame(input int len, input logic aborted);
        byte_q_t payload;
        byte_q_t expected;
        beat_t   beats[$];
        beat_t   b;
        int      pos;
        int      lanes;
        pos = 0;
        while (pos < len) begin
            lanes  = (len - pos > LANES) ? LANES : len - pos;
            // lanes above keep carry garbage on purpose
            b.data = {$random(seed), $random(seed)};
            b.keep = low_lanes(lanes);
            b.last = (pos + lanes == len);
            b.user = aborted && b.last;
            for (int i = 0; i < lanes; i++) begin
                payload.push_back(b.data[8*i +: 8]);
            end
            beats.push_back(b);
            pos = pos + lanes;
        end
        expected = expected_bytes(payload, aborted);
        foreach (expected[k]) begin
            exp_bytes.push_back(expected[k]);
        end
        exp_len.push_back(expected.size());
        exp_abort.push_back(aborted);
        frames_sent++;
        foreach (beats[k]) begin
            if (timeouts == 0) begin
                send_beat(beats[k]);
                if (gap_enable && ($unsigned($random(seed)) % 4) == 0) begin
                    repeat (1 + int'($unsigned($random(seed)) % 3)) @(negedge clk);
                end
            end
        end
    endtask

    task automatic close_frame(input beat_t b);
        byte_q_t expected;
        int      len;
        int      beats;
        logic    aborted;
        if (exp_len.size() == 0) begin
            protocol_errors++;
            $display("error at %0t: output frame with no frame sent", $time);
        end else begin
            len     = exp_len.pop_front();
            aborted = exp_abort.pop_front();
            for (int i = 0; i < len; i++) begin
                expected.push_back(exp_bytes.pop_front());
            end
            beats = (len + LANES - 1) / LANES;
            assert (got_bytes.size() == len) else begin
                data_errors++;
                $display("error at %0t: frame %0d has %0d bytes, expected %0d",
                         $time, frames_seen, got_bytes.size(), len);
            end
            for (int i = 0; i < len && i < got_bytes.size(); i++) begin
                assert (got_bytes[i] == expected[i]) else begin
                    data_errors++;
                    $display("error at %0t: frame %0d byte %0d is %h, expected %h",
                             $time, frames_seen, i, got_bytes[i], expected[i]);
                end
            end
            // overflow beat exists exactly when the fcs does not fit
            assert (got_beats == beats && b.keep == low_lanes(len - LANES * (beats - 1)))
                else begin
                protocol_errors++;
                $display("error at %0t: frame %0d has %0d beats, last keep %b",
                         $time, frames_seen, got_beats, b.keep);
            end
            assert (b.user == aborted) else begin
                protocol_errors++;
                $display("error at %0t: frame %0d user is %b", $time, frames_seen, b.user);
            end
            frames_seen++;
        end
        got_bytes = {};
        got_beats = 0;
    endtask

    task automatic take_beat(input beat_t b);
        for (int i = 0; i < LANES; i++) begin
            if (b.keep[i]) begin
                got_bytes.push_back(b.data[8*i +: 8]);
            end else begin
                assert (b.data[8*i +: 8] == 8'd0) else begin
                    data_errors++;
                    $display("error at %0t: lane %0d beyond keep is not zero", $time, i);
                end
            end
        end
        got_beats++;
        assert (b.keep != '0 && (b.keep & (b.keep + 8'd1)) == '0) else begin
            protocol_errors++;
            $display("error at %0t: output keep %b not contiguous", $time, b.keep);
        end
        if (!b.last) begin
            assert (b.keep == 8'hff && !b.user) else begin
                protocol_errors++;
                $display("error at %0t: partial or user beat before last", $time);
            end
        end else begin
            close_frame(b);
        end
    endtask

    // comparator on the output side
    always @(posedge clk) begin
        if (!rst) begin
            if (busy) begin
                busy_seen = 1'b1;
            end
            if (was_stalled) begin
                assert (out_valid && out_beat == stalled_beat) else begin
                    protocol_errors++;
                    $display("error at %0t: output beat changed while stalled", $time);
                end
            end
            was_stalled  = out_valid && !out_ready;
            stalled_beat = out_beat;
            if (out_valid && out_ready) begin
                take_beat(out_beat);
            end
        end
    end

    always @(negedge clk) begin
        if (stall_enable) begin
            out_ready = ($unsigned($random(seed)) % 3) != 0;
        end else begin
            out_ready = 1'b1;
        end
    end

    initial begin
        int   len;
        int   waited;
        logic aborted;
        logic prev_aborted;
        logic drained;
        seed            = 32'h43d7_c2de;
        rst             = 1'b1;
        in_beat         = '0;
        in_valid        = 1'b0;
        out_ready       = 1'b1;
        stall_enable    = 1'b0;
        gap_enable      = 1'b0;
        got_beats       = 0;
        frames_sent     = 0;
        frames_seen     = 0;
        data_errors     = 0;
        protocol_errors = 0;
        timeouts        = 0;
        busy_seen       = 1'b0;
        was_stalled     = 1'b0;
        stalled_beat    = '0;
        prev_aborted    = 1'b0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        assert (!out_valid && !in_ready && !busy) else begin
            protocol_errors++;
            $display("error at %0t: outputs not low after reset", $time);
        end
        rst = 1'b0;
        @(negedge clk);
        assert (in_ready) else begin
            protocol_errors++;
            $display("error at %0t: in_ready did not rise after reset", $time);
        end

        // steady flow first, then back-pressure and input gaps
        for (int f = 0; f < FRAMES && timeouts == 0; f++) begin
            if (f == FRAMES / 3) begin
                stall_enable = 1'b1;
                gap_enable   = 1'b1;
            end
            if (f < 16) begin
                len = f + 1;
            end else begin
                len = 1 + int'($unsigned($random(seed)) % 40);
            end
            aborted = (f == 16) ||
                      (f > 17 && !prev_aborted && ($unsigned($random(seed)) % 6) == 0);
            send_frame(len, aborted);
            prev_aborted = aborted;
        end

        stall_enable = 1'b0;
        waited  = 0;
        drained = 1'b0;
        while (!drained && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
            drained = (frames_seen == frames_sent) && !out_valid;
        end
        if (!drained) begin
            timeouts++;
            $display("output did not drain, %0d of %0d frames seen", frames_seen, frames_sent);
        end
        repeat (3) @(negedge clk);
        assert (!busy && busy_seen) else begin
            protocol_errors++;
            $display("error at %0t: busy %b at idle, seen high %b", $time, busy, busy_seen);
        end

        $display("frames %0d, data errors %0d, protocol errors %0d, timeouts %0d",
                 frames_seen, data_errors, protocol_errors, timeouts);
        if (data_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* eth_fcs_insert.f */
logic/eth_fcs_pkg.sv
logic/eth_crc_64.sv
logic/fcs_splice.sv
logic/fcs_framer.sv
logic/axis_skid_reg.sv
logic/eth_fcs_insert_64.sv
sim/tb_eth_fcs_insert.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_eth_fcs_insert
FILELIST  ?= eth_fcs_insert.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
